// ==== rca_unit.f ====
src/rca_pkg.sv
src/rca_config_regs.sv
src/rca_grid_control.sv
src/rca_grid.sv
src/rca_grid_wb.sv
src/rca_unit.sv
sim/rca_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the rca_unit testbench

VERILATOR ?= verilator
TOP       ?= rca_unit_tb
FILELIST  ?= rca_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/rca_unit_tb.sv ====
`timescale 1ns/1ns

module rca_unit_tb import rca_pkg::*; ();

    localparam int NUM_IO_UNITS   = 4;
    localparam int FIFO_DEPTH     = 4;
    localparam int NUM_REQS       = 300;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 20 + 500;

    localparam int MODE_RANDOM  = 0;
    localparam int MODE_STALL   = 1;
    localparam int MODE_FIRST   = 2;
    localparam int MODE_IDLE    = 3;
    localparam int MODE_OOR_CFG = 4;
    localparam int MODE_SET0    = 5;

    logic     clk;
    logic     arst_n;
    logic     new_request;
    rca_req_t req;
    logic     issue_ready;
    logic     wb_stall;
    rca_wb_t  rca_wb;
    logic     config_locked;

    logic [31:0] rng_state = 32'd71;
    int          error_count;
    int          check_count;
    int          issued;
    id_t         next_id;

    // configuration mirror
    io_sel_t   mir_io    [NUM_RCAS][NUM_IO_UNITS];
    data_t     mir_const [NUM_RCAS][NUM_IO_UNITS];
    unit_idx_t mir_res   [NUM_RCAS][NUM_WRITE_PORTS];
    rca_wb_t   exp_q [$];  // expected results in issue order

    rca_unit #(.NUM_IO_UNITS(NUM_IO_UNITS), .FIFO_DEPTH(FIFO_DEPTH)) rca_unit_i (
        .clk,
        .arst_n,
        .new_request,
        .req,
        .issue_ready,
        .wb_stall,
        .rca_wb,
        .config_locked
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:8]) % n;  // skip the weak low bits
    endfunction

    function automatic rca_wb_t model_use(input rca_req_t r);
        rca_wb_t e;
        data_t   outs [NUM_IO_UNITS];
        data_t   prev;
        data_t   src;
        e      = '0;
        e.done = 1'b1;
        e.id   = r.id;
        prev   = '0;
        for (int i = 0; i < NUM_IO_UNITS; i++) begin
            case (mir_io[r.rca_sel][i])
                IO_SEL_RS0:  src = r.rs0;
                IO_SEL_RS1:  src = r.rs1;
                IO_SEL_PREV: src = prev;
                default:     src = '0;
            endcase
            outs[i] = src + mir_const[r.rca_sel][i];
            prev    = outs[i];
        end
        for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
            for (int u = 0; u < NUM_IO_UNITS; u++) begin
                if (int'(mir_res[r.rca_sel][p]) == u)
                    e.rd[p] = outs[u];  // past the last unit stays zero
            end
        end
        return e;
    endfunction

    task automatic apply_cfg(input rca_req_t r);
        for (int u = 0; u < NUM_IO_UNITS; u++) begin
            if (int'(r.unit) == u && r.cfg_kind == CFG_IO_MUX)
                mir_io[r.rca_sel][u] = r.rs0[1:0];
            if (int'(r.unit) == u && r.cfg_kind == CFG_CONST)
                mir_const[r.rca_sel][u] = r.rs0;
        end
        for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
            if (int'(r.unit) == p && r.cfg_kind == CFG_RESULT_MUX)
                mir_res[r.rca_sel][p] = r.rs0[3:0];
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_id(input string name, input id_t got, input id_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, expected);
        end
    endtask

    task automatic sample_result();
        rca_wb_t e;
        if (wb_stall)
            check_bit("rca_wb.done", rca_wb.done, 1'b0);
        if (rca_wb.done === 1'b1) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("done pulse at %0t with no outstanding request", $time);
            end else begin
                e = exp_q.pop_front();
                check_id("rca_wb.id", rca_wb.id, e.id);
                for (int p = 0; p < NUM_WRITE_PORTS; p++)
                    check_data($sformatf("rca_wb.rd[%0d]", p), rca_wb.rd[p], e.rd[p]);
            end
        end
    endtask

    // one clock: drive on the falling edge, sample before the rising edge
    task automatic run_cycle(input int mode, output logic took);
        rca_req_t r;
        rca_wb_t  e;
        logic     issue;
        logic     stall;
        int       pick;
        @(negedge clk);
        check_bit("config_locked", config_locked, exp_q.size() != 0);
        r         = '0;
        issue     = 1'b0;
        stall     = 1'b0;
        r.id      = next_id;
        r.rca_sel = rca_sel_t'(rand_below(2));
        r.rs0     = next_rand();
        r.rs1     = next_rand();
        case (mode)
            MODE_RANDOM: begin
                stall = rand_below(4) == 0;
                pick  = rand_below(4);
                if (!config_locked && pick < 2) begin
                    issue      = 1'b1;
                    r.is_cfg   = 1'b1;
                    r.cfg_kind = cfg_kind_t'(rand_below(4));
                    r.unit     = unit_idx_t'(rand_below(NUM_IO_UNITS + 2));
                    if (r.cfg_kind == CFG_IO_MUX)
                        r.rs0 = data_t'(rand_below(4));
                    else if (r.cfg_kind == CFG_RESULT_MUX)
                        r.rs0 = data_t'(rand_below(NUM_IO_UNITS + 2));
                end else if (pick < 2 || (!config_locked && pick == 2)) begin
                    issue = 1'b1;
                end
            end
            MODE_STALL: begin
                stall = 1'b1;
                issue = 1'b1;
            end
            MODE_FIRST: issue = 1'b1;
            MODE_OOR_CFG: begin
                issue      = 1'b1;
                r.rca_sel  = '0;
                r.is_cfg   = 1'b1;
                r.cfg_kind = CFG_RESULT_MUX;
                r.unit     = unit_idx_t'(1);
                r.rs0      = data_t'(NUM_IO_UNITS);  // first index past the last unit
            end
            MODE_SET0: begin
                issue     = 1'b1;
                r.rca_sel = '0;
            end
            default: ;
        endcase
        issue = issue && issue_ready;
        if (issue) begin
            if (r.is_cfg) begin
                e      = '0;
                e.done = 1'b1;
                e.id   = r.id;
                apply_cfg(r);
            end else if (mode == MODE_FIRST) begin
                e       = '0;
                e.done  = 1'b1;
                e.id    = r.id;
                e.rd[0] = r.rs0;  // reset config passes rs0 through
                e.rd[1] = r.rs0;
            end else begin
                e = model_use(r);
            end
            exp_q.push_back(e);
            next_id++;
            issued++;
        end
        new_request = issue;
        req         = r;
        wb_stall    = stall;
        took        = issue;
        #10;
        sample_result();
    endtask

    initial begin : main
        logic took;
        int   accepted;
        arst_n      = 1'b0;
        new_request = 1'b0;
        req         = '0;
        wb_stall    = 1'b0;
        next_id     = '0;
        issued      = 0;
        error_count = 0;
        check_count = 0;
        for (int r = 0; r < NUM_RCAS; r++) begin
            for (int u = 0; u < NUM_IO_UNITS; u++) begin
                mir_io[r][u]    = '0;
                mir_const[r][u] = '0;
            end
            for (int p = 0; p < NUM_WRITE_PORTS; p++)
                mir_res[r][p] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #10;
        check_bit("issue_ready", issue_ready, 1'b1);
        check_bit("config_locked", config_locked, 1'b0);
        check_bit("rca_wb.done", rca_wb.done, 1'b0);

        run_cycle(MODE_FIRST, took);
        while (issued < NUM_REQS)
            run_cycle(MODE_RANDOM, took);
        while (exp_q.size() != 0)
            run_cycle(MODE_IDLE, took);

        // port 1 of set 0 selects no unit, so its word reads zero
        run_cycle(MODE_OOR_CFG, took);
        run_cycle(MODE_SET0, took);
        while (exp_q.size() != 0)
            run_cycle(MODE_IDLE, took);

        // long stall fills the FIFO plus the grid and writeback registers
        accepted = 0;
        repeat (FIFO_DEPTH + 8) begin
            run_cycle(MODE_STALL, took);
            if (took)
                accepted++;
        end
        check_bit("issue_ready", issue_ready, 1'b0);
        if (accepted != FIFO_DEPTH + 2) begin
            error_count++;
            $display("long stall accepted %0d requests instead of %0d",
                     accepted, FIFO_DEPTH + 2);
        end
        while (exp_q.size() != 0)
            run_cycle(MODE_IDLE, took);
        check_bit("issue_ready", issue_ready, 1'b1);
        run_cycle(MODE_IDLE, took);

        $display("errors %0d checks %0d", error_count, check_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * 100);
        $display("timeout after %0d cycles, requests stopped completing", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== src/rca_unit.sv ====
`timescale 1ns/1ns

module rca_unit import rca_pkg::*; #(
    parameter int NUM_IO_UNITS = 4,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     new_request,
    input  rca_req_t req,
    output logic     issue_ready,
    input  logic     wb_stall,
    output rca_wb_t  rca_wb,
    output logic     config_locked
);

    logic                              cfg_wr;
    rca_op_t                           op;
    logic                              op_valid;
    logic                              grid_ready;
    logic                              grid_busy;
    logic                              wb_busy;
    io_sel_t   [NUM_IO_UNITS-1:0]      io_sels;
    data_t     [NUM_IO_UNITS-1:0]      constants;
    unit_idx_t [NUM_WRITE_PORTS-1:0]   result_sels;
    rca_op_t                           grid_op;
    data_t     [NUM_IO_UNITS-1:0]      unit_out;
    logic                              grid_valid;
    logic                              wb_ready;
    rca_sel_t                          wb_rca_sel;

    rca_config_regs #(.NUM_IO_UNITS(NUM_IO_UNITS)) config_regs_i (
        .clk,
        .arst_n,
        .cfg_wr,
        .cfg_req      (req),
        .grid_rca_sel (op.rca_sel),
        .wb_rca_sel,
        .io_sels,
        .constants,
        .result_sels
    );

    rca_grid_control #(.FIFO_DEPTH(FIFO_DEPTH)) grid_control_i (
        .clk,
        .arst_n,
        .new_request,
        .req,
        .grid_ready,
        .grid_busy,
        .wb_busy,
        .issue_ready,
        .cfg_wr,
        .op,
        .op_valid,
        .config_locked
    );

    rca_grid #(.NUM_IO_UNITS(NUM_IO_UNITS)) grid_i (
        .clk,
        .arst_n,
        .op,
        .op_valid,
        .grid_ready,
        .io_sels,
        .constants,
        .wb_ready,
        .grid_op,
        .unit_out,
        .grid_valid,
        .grid_busy
    );

    rca_grid_wb #(.NUM_IO_UNITS(NUM_IO_UNITS)) grid_wb_i (
        .clk,
        .arst_n,
        .grid_op,
        .unit_out,
        .grid_valid,
        .result_sels,
        .wb_stall,
        .wb_ready,
        .wb_rca_sel,
        .wb_busy,
        .rca_wb
    );

endmodule

// ==== src/rca_grid_wb.sv ====
`timescale 1ns/1ns

module rca_grid_wb import rca_pkg::*; #(
    parameter int NUM_IO_UNITS = 4
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  rca_op_t                           grid_op,
    input  data_t     [NUM_IO_UNITS-1:0]      unit_out,
    input  logic                              grid_valid,
    input  unit_idx_t [NUM_WRITE_PORTS-1:0]   result_sels,
    input  logic                              wb_stall,
    output logic                              wb_ready,
    output rca_sel_t                          wb_rca_sel,
    output logic                              wb_busy,
    output rca_wb_t                           rca_wb
);

    logic                         wb_valid;
    id_t                          wb_id;
    data_t [NUM_WRITE_PORTS-1:0]  wb_rd;
    data_t [NUM_WRITE_PORTS-1:0]  rd_next;
    logic                         load;

    // result muxes of the entry about to load
    assign wb_rca_sel = grid_op.rca_sel;
    assign wb_ready   = !wb_valid || !wb_stall;
    assign load       = grid_valid && wb_ready;
    assign wb_busy    = wb_valid;

    always_comb begin
        for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
            rd_next[p] = '0;  // also for indexes past the last unit
            if (!grid_op.is_cfg) begin
                for (int u = 0; u < NUM_IO_UNITS; u++) begin
                    if (result_sels[p] == unit_idx_t'(u))
                        rd_next[p] = unit_out[u];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            wb_valid <= 1'b0;
        else if (wb_ready)
            wb_valid <= grid_valid;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wb_id <= grid_op.id;
            wb_rd <= rd_next;
        end
    end

    assign rca_wb.done = wb_valid && !wb_stall;
    assign rca_wb.id   = wb_id;
    assign rca_wb.rd   = wb_rd;

    // grid entry waits out the stall
    a_stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
        grid_valid && !wb_ready |=> grid_valid && $stable(grid_op) && $stable(unit_out));

endmodule

// ==== src/rca_grid.sv ====
`timescale 1ns/1ns

module rca_grid import rca_pkg::*; #(
    parameter int NUM_IO_UNITS = 4
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  rca_op_t                      op,
    input  logic                         op_valid,
    output logic                         grid_ready,
    input  io_sel_t [NUM_IO_UNITS-1:0]   io_sels,
    input  data_t   [NUM_IO_UNITS-1:0]   constants,
    input  logic                         wb_ready,
    output rca_op_t                      grid_op,
    output data_t   [NUM_IO_UNITS-1:0]   unit_out,
    output logic                         grid_valid,
    output logic                         grid_busy
);

    data_t [NUM_IO_UNITS-1:0] chain;
    logic                     load;

    // units in order, each sees the one before it
    always_comb begin : eval_chain
        data_t prev;
        data_t unit_in;
        prev = '0;
        for (int i = 0; i < NUM_IO_UNITS; i++) begin
            case (io_sels[i])
                IO_SEL_RS0:  unit_in = op.rs0;
                IO_SEL_RS1:  unit_in = op.rs1;
                IO_SEL_PREV: unit_in = prev;
                default:     unit_in = '0;
            endcase
            chain[i] = unit_in + constants[i];
            prev     = chain[i];
        end
    end

    assign grid_ready = !grid_valid || wb_ready;
    assign load       = op_valid && grid_ready;
    assign grid_busy  = grid_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            grid_valid <= 1'b0;
        else if (grid_ready)
            grid_valid <= op_valid;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            grid_op  <= op;
            unit_out <= chain;
        end
    end

    // fifo head waits while the grid is full
    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        op_valid && !grid_ready |=> op_valid && $stable(op));

endmodule

// ==== src/rca_grid_control.sv ====
`timescale 1ns/1ns

module rca_grid_control import rca_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     new_request,
    input  rca_req_t req,
    input  logic     grid_ready,
    input  logic     grid_busy,
    input  logic     wb_busy,
    output logic     issue_ready,
    output logic     cfg_wr,
    output rca_op_t  op,
    output logic     op_valid,
    output logic     config_locked
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    rca_op_t          fifo_mem [FIFO_DEPTH];
    rca_op_t          push_op;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign issue_ready = count != CNT_W'(FIFO_DEPTH);
    assign push        = new_request && issue_ready;
    assign cfg_wr      = push && req.is_cfg;  // fields update on the taking edge
    assign op_valid    = count != '0;
    assign op          = fifo_mem[rd_ptr];
    assign pop         = op_valid && grid_ready;

    // anything in flight blocks reconfiguration
    assign config_locked = op_valid || grid_busy || wb_busy;

    assign push_op = '{id: req.id, rca_sel: req.rca_sel, is_cfg: req.is_cfg,
                       rs0: req.rs0, rs1: req.rs1};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            fifo_mem[wr_ptr] <= push_op;
    end

    // a push never lands on the unread head
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> count == '0 || wr_ptr != rd_ptr);

    // core must hold config requests until the pipeline drains
    a_no_cfg_locked: assert property (@(posedge clk) disable iff (!arst_n)
        cfg_wr |-> !config_locked);

endmodule

// ==== src/rca_config_regs.sv ====
`timescale 1ns/1ns

module rca_config_regs import rca_pkg::*; #(
    parameter int NUM_IO_UNITS = 4
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  cfg_wr,
    input  rca_req_t                              cfg_req,
    input  rca_sel_t                              grid_rca_sel,
    input  rca_sel_t                              wb_rca_sel,
    output io_sel_t   [NUM_IO_UNITS-1:0]          io_sels,
    output data_t     [NUM_IO_UNITS-1:0]          constants,
    output unit_idx_t [NUM_WRITE_PORTS-1:0]       result_sels
);

    io_sel_t   [NUM_IO_UNITS-1:0]    io_sel_q    [NUM_RCAS];
    data_t     [NUM_IO_UNITS-1:0]    const_q     [NUM_RCAS];
    unit_idx_t [NUM_WRITE_PORTS-1:0] res_sel_q   [NUM_RCAS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < NUM_RCAS; r++) begin
                io_sel_q[r]  <= '0;
                const_q[r]   <= '0;
                res_sel_q[r] <= '0;  // every port reads unit 0
            end
        end else if (cfg_wr) begin
            case (cfg_req.cfg_kind)
                CFG_IO_MUX: begin
                    for (int u = 0; u < NUM_IO_UNITS; u++) begin
                        if (cfg_req.unit == unit_idx_t'(u))
                            io_sel_q[cfg_req.rca_sel][u] <= io_sel_t'(cfg_req.rs0[1:0]);
                    end
                end
                CFG_CONST: begin
                    for (int u = 0; u < NUM_IO_UNITS; u++) begin
                        if (cfg_req.unit == unit_idx_t'(u))
                            const_q[cfg_req.rca_sel][u] <= cfg_req.rs0;
                    end
                end
                CFG_RESULT_MUX: begin
                    // unit field names the write port here
                    for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
                        if (cfg_req.unit == unit_idx_t'(p))
                            res_sel_q[cfg_req.rca_sel][p] <= unit_idx_t'(cfg_req.rs0[3:0]);
                    end
                end
                default: ;  // kind 3 dropped
            endcase
        end
    end

    // grid reads the set of the entry entering it
    assign io_sels     = io_sel_q[grid_rca_sel];
    assign constants   = const_q[grid_rca_sel];
    assign result_sels = res_sel_q[wb_rca_sel];

endmodule

// ==== src/rca_pkg.sv ====
package rca_pkg;

    localparam int XLEN            = 32;
    localparam int NUM_RCAS        = 2;
    localparam int NUM_WRITE_PORTS = 2;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [2:0]      id_t;
    typedef logic [0:0]      rca_sel_t;
    typedef logic [1:0]      io_sel_t;
    typedef logic [3:0]      unit_idx_t;  // io unit or write port
    typedef logic [1:0]      cfg_kind_t;

    // io mux choices
    localparam io_sel_t IO_SEL_RS0  = 2'd0;
    localparam io_sel_t IO_SEL_RS1  = 2'd1;
    localparam io_sel_t IO_SEL_PREV = 2'd2;  // previous unit, zero for unit 0
    localparam io_sel_t IO_SEL_ZERO = 2'd3;

    // configuration write kinds, 3 is ignored
    localparam cfg_kind_t CFG_IO_MUX     = 2'd0;
    localparam cfg_kind_t CFG_CONST      = 2'd1;
    localparam cfg_kind_t CFG_RESULT_MUX = 2'd2;

    typedef struct packed {
        id_t       id;
        rca_sel_t  rca_sel;
        logic      is_cfg;
        cfg_kind_t cfg_kind;
        unit_idx_t unit;
        data_t     rs0;      // new field value on config requests
        data_t     rs1;
    } rca_req_t;

    typedef struct packed {
        id_t      id;
        rca_sel_t rca_sel;
        logic     is_cfg;
        data_t    rs0;
        data_t    rs1;
    } rca_op_t;

    typedef struct packed {
        logic                             done;
        id_t                              id;
        data_t [NUM_WRITE_PORTS-1:0]      rd;
    } rca_wb_t;

endpackage
